// ==== mvm_pkg.sv ====
`default_nettype none

package mvm_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------

    localparam int num_cores    = 8;   // One matrix row per core.
    localparam int num_cols     = 128;
    localparam int col_w        = 7;
    localparam int pair_w       = 6;   // Column address without its parity bit.
    localparam int row_w        = 3;
    localparam int data_w       = 32;
    localparam int drain_cycles = 3;   // MAC pipeline depth behind the last exec cycle.

    // ------------------------------
    // Stream words
    // ------------------------------

    // One matrix write covers two neighbouring columns of a row.
    typedef struct packed {
        logic [row_w-1:0]    row;
        logic [pair_w-1:0]   pair;
        logic [2*data_w-1:0] data;   // Column 2*pair low, column 2*pair+1 high.
    } mat_word_t;

    typedef struct packed {
        logic [col_w-1:0]  addr;
        logic [data_w-1:0] data;
    } vec_word_t;

    // Broadcast from the sequencer and the vector buffer to every core.
    typedef struct packed {
        logic              init;        // Clears the accumulators.
        logic              exec;        // One column of the dot product.
        logic              out_period;  // Shift the result chain by one core.
        logic              update;      // Show the fresh sums on the chain.
        logic [col_w-1:0]  addr;
        logic [data_w-1:0] src;         // Vector element one cycle behind addr.
    } exec_bus_t;

    // ------------------------------
    // Sequencer
    // ------------------------------

    typedef enum logic [2:0] {
        idle,
        clear,
        run,
        drain,
        shift
    } seq_state_t;

endpackage

`default_nettype wire

// ==== mvm_core.sv ====
`default_nettype none

module mvm_core (
    input  wire logic                            clk,
    input  wire logic                            mat_v,
    input  wire logic [mvm_pkg::pair_w-1:0]      mat_a,
    input  wire logic [2*mvm_pkg::data_w-1:0]    mat_d,
    input  wire mvm_pkg::exec_bus_t              bus,
    input  wire logic [mvm_pkg::data_w-1:0]      acc_next,
    output logic      [mvm_pkg::data_w-1:0]      acc
);

    // ------------------------------
    // Row storage
    // ------------------------------

    logic [mvm_pkg::data_w-1:0] bank_even [0:2**mvm_pkg::pair_w-1];
    logic [mvm_pkg::data_w-1:0] bank_odd  [0:2**mvm_pkg::pair_w-1];

    logic [mvm_pkg::data_w-1:0] mat_q;     // Matrix element one cycle after exec.
    logic [mvm_pkg::data_w-1:0] m_q;
    logic [mvm_pkg::data_w-1:0] s_q;
    logic [mvm_pkg::data_w-1:0] acc_left;  // Running dot product.
    logic [mvm_pkg::data_w-1:0] acc_right; // Result shift chain link.

    logic init_d1;
    logic init_d2;
    logic exec_d1;
    logic exec_d2;

    always_ff @(posedge clk) begin
        if (mat_v) begin
            bank_even[mat_a] <= mat_d[mvm_pkg::data_w-1:0];
            bank_odd[mat_a]  <= mat_d[2*mvm_pkg::data_w-1:mvm_pkg::data_w];
        end
    end

    // Column parity selects the bank.
    always_ff @(posedge clk) begin
        if (bus.exec) begin
            if (bus.addr[0]) begin
                mat_q <= bank_odd[bus.addr[mvm_pkg::col_w-1:1]];
            end else begin
                mat_q <= bank_even[bus.addr[mvm_pkg::col_w-1:1]];
            end
        end
    end

    // ------------------------------
    // Multiply-accumulate pipeline
    // ------------------------------

    always_ff @(posedge clk) begin
        init_d1 <= bus.init;
        init_d2 <= init_d1;
        exec_d1 <= bus.exec;
        exec_d2 <= exec_d1;
    end

    // Operand register keeps the multiplier off the bank read path.
    always_ff @(posedge clk) begin
        if (exec_d1) begin
            m_q <= mat_q;
            s_q <= bus.src;
        end
    end

    always_ff @(posedge clk) begin
        if (init_d2) begin
            acc_left <= '0;
        end else if (exec_d2) begin
            acc_left <= acc_left + m_q * s_q;  // Wraps at 32 bits.
        end
    end

    // ------------------------------
    // Result chain
    // ------------------------------

    always_ff @(posedge clk) begin
        if (bus.out_period) begin
            acc_right <= acc_next;
        end
    end

    always_comb begin
        if (bus.update) begin
            acc = acc_left;
        end else begin
            acc = acc_right;
        end
    end

    // The sequencer keeps clear and execute in separate cycles, so a clear never
    // lands on top of a pending product.
    a_init_exec_excl : assert property (@(posedge clk) !(bus.init && bus.exec));

endmodule

`default_nettype wire

// ==== mvm_operand_store.sv ====
`default_nettype none

module mvm_operand_store (
    input  wire logic                               clk,
    input  wire logic                               rst,

    input  wire mvm_pkg::mat_word_t                 mat_in,
    input  wire logic                               mat_valid,
    output logic                                    mat_ready,

    input  wire mvm_pkg::vec_word_t                 vec_in,
    input  wire logic                               vec_valid,
    output logic                                    vec_ready,

    input  wire logic                               busy,
    input  wire logic [mvm_pkg::col_w-1:0]          rd_addr,
    output logic      [mvm_pkg::data_w-1:0]         rd_data,

    output logic      [mvm_pkg::num_cores-1:0]      mat_v,
    output logic      [mvm_pkg::pair_w-1:0]         mat_a,
    output logic      [2*mvm_pkg::data_w-1:0]       mat_d
);

    logic                          mat_fire;
    logic                          vec_fire;
    logic [mvm_pkg::num_cores-1:0] row_dec;

    logic [mvm_pkg::data_w-1:0] vec_mem [0:mvm_pkg::num_cols-1];

    // ------------------------------
    // Load handshakes
    // ------------------------------

    assign mat_ready = !busy;  // Loads are closed for the whole run.
    assign vec_ready = !busy;

    assign mat_fire = mat_valid && mat_ready;
    assign vec_fire = vec_valid && vec_ready;

    // ------------------------------
    // Matrix write decode
    // ------------------------------

    always_comb begin
        row_dec = '0;
        row_dec[mat_in.row] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mat_v <= '0;
        end else if (mat_fire) begin
            mat_v <= row_dec;
        end else begin
            mat_v <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mat_fire) begin
            mat_a <= mat_in.pair;
            mat_d <= mat_in.data;
        end
    end

    // ------------------------------
    // Vector buffer
    // ------------------------------

    always_ff @(posedge clk) begin
        if (vec_fire) begin
            vec_mem[vec_in.addr] <= vec_in.data;
        end
    end

    // Registered read lines the element up with the core's bank read.
    always_ff @(posedge clk) begin
        rd_data <= vec_mem[rd_addr];
    end

    // ------------------------------
    // Checks
    // ------------------------------

    a_mat_v_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(mat_v)
    );

    // A strobe may trail into the clear cycle, but never into the run itself.
    a_no_write_in_run : assert property (
        @(posedge clk) disable iff (rst)
        (mat_v != '0) |-> !$past(busy)
    );

endmodule

`default_nettype wire

// ==== mvm_sequencer.sv ====
`default_nettype none

module mvm_sequencer (
    input  wire logic        clk,
    input  wire logic        rst,

    input  wire logic        start_valid,
    output logic             start_ready,

    output logic             res_valid,
    input  wire logic        res_ready,

    output logic             busy,
    output mvm_pkg::exec_bus_t bus
);

    mvm_pkg::seq_state_t state;
    mvm_pkg::seq_state_t state_next;

    logic [mvm_pkg::col_w-1:0] col_cnt;
    logic [1:0]                drain_cnt;
    logic [mvm_pkg::row_w-1:0] beat_cnt;

    logic start_fire;
    logic res_fire;

    assign start_fire = start_valid && start_ready;
    assign res_fire   = res_valid && res_ready;

    // ------------------------------
    // State machine
    // ------------------------------

    always_comb begin
        state_next = state;
        case (state)
            mvm_pkg::idle: begin
                if (start_fire) begin
                    state_next = mvm_pkg::clear;
                end
            end
            mvm_pkg::clear: begin
                state_next = mvm_pkg::run;
            end
            mvm_pkg::run: begin
                if (col_cnt == mvm_pkg::num_cols - 1) begin
                    state_next = mvm_pkg::drain;
                end
            end
            mvm_pkg::drain: begin
                if (drain_cnt == mvm_pkg::drain_cycles - 1) begin
                    state_next = mvm_pkg::shift;
                end
            end
            mvm_pkg::shift: begin
                if (res_fire && beat_cnt == mvm_pkg::num_cores - 1) begin
                    state_next = mvm_pkg::idle;
                end
            end
            default: begin
                state_next = mvm_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= mvm_pkg::idle;
            col_cnt   <= '0;
            drain_cnt <= '0;
            beat_cnt  <= '0;
        end else begin
            state <= state_next;

            if (state == mvm_pkg::run) begin
                col_cnt <= col_cnt + 1'b1;
            end else begin
                col_cnt <= '0;
            end

            if (state == mvm_pkg::drain) begin
                drain_cnt <= drain_cnt + 1'b1;
            end else begin
                drain_cnt <= '0;
            end

            if (state != mvm_pkg::shift) begin
                beat_cnt <= '0;
            end else if (res_fire) begin
                beat_cnt <= beat_cnt + 1'b1;  // Row now at core 0.
            end
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    assign start_ready = (state == mvm_pkg::idle);
    assign busy        = (state != mvm_pkg::idle);
    assign res_valid   = (state == mvm_pkg::shift);

    always_comb begin
        bus            = '0;
        bus.init       = (state == mvm_pkg::clear);
        bus.exec       = (state == mvm_pkg::run);
        bus.addr       = col_cnt;
        bus.update     = (state == mvm_pkg::shift) && (beat_cnt == '0);  // First beat only.
        bus.out_period = res_fire;
    end

    // ------------------------------
    // Checks
    // ------------------------------

    a_res_hold : assert property (
        @(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid
    );

    // Clear, 128 columns and the drain put the first result 133 cycles out.
    a_first_result : assert property (
        @(posedge clk) disable iff (rst)
        start_fire |=> !res_valid [*132] ##1 res_valid
    );

endmodule

`default_nettype wire

// ==== mvm_top.sv ====
`default_nettype none

module mvm_top (
    input  wire logic                          clk,
    input  wire logic                          rst,

    input  wire mvm_pkg::mat_word_t            mat_in,
    input  wire logic                          mat_valid,
    output logic                               mat_ready,

    input  wire mvm_pkg::vec_word_t            vec_in,
    input  wire logic                          vec_valid,
    output logic                               vec_ready,

    input  wire logic                          start_valid,
    output logic                               start_ready,

    output logic                               res_valid,
    input  wire logic                          res_ready,
    output logic      [mvm_pkg::data_w-1:0]    res_data
);

    mvm_pkg::exec_bus_t seq_bus;
    mvm_pkg::exec_bus_t core_bus;

    logic                           busy;
    logic [mvm_pkg::data_w-1:0]     rd_data;
    logic [mvm_pkg::num_cores-1:0]  mat_v;
    logic [mvm_pkg::pair_w-1:0]     mat_a;
    logic [2*mvm_pkg::data_w-1:0]   mat_d;

    // Link i is core i's output and the extra top link feeds zeros into core 7.
    wire  [mvm_pkg::data_w-1:0]     acc_link [0:mvm_pkg::num_cores];

    mvm_operand_store u_store (
        .clk       (clk),
        .rst       (rst),
        .mat_in    (mat_in),
        .mat_valid (mat_valid),
        .mat_ready (mat_ready),
        .vec_in    (vec_in),
        .vec_valid (vec_valid),
        .vec_ready (vec_ready),
        .busy      (busy),
        .rd_addr   (seq_bus.addr),
        .rd_data   (rd_data),
        .mat_v     (mat_v),
        .mat_a     (mat_a),
        .mat_d     (mat_d)
    );

    mvm_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .busy        (busy),
        .bus         (seq_bus)
    );

    always_comb begin
        core_bus     = seq_bus;
        core_bus.src = rd_data;  // Vector element for the previous addr.
    end

    // ------------------------------
    // Core chain
    // ------------------------------

    assign acc_link[mvm_pkg::num_cores] = '0;

    for (genvar i = 0; i < mvm_pkg::num_cores; i++) begin : g_core
        mvm_core u_core (
            .clk      (clk),
            .mat_v    (mat_v[i]),
            .mat_a    (mat_a),
            .mat_d    (mat_d),
            .bus      (core_bus),
            .acc_next (acc_link[i+1]),
            .acc      (acc_link[i])
        );
    end

    assign res_data = acc_link[0];

endmodule

`default_nettype wire

// ==== tb_mvm_top.sv ====
`default_nettype none

module tb_mvm_top;

    localparam int num_runs       = 4;
    localparam int load_cycles    = 250;
    localparam int run_cycles     = 200;
    localparam int timeout_cycles = num_runs * (load_cycles + run_cycles) * 2;

    logic                   clk;
    logic                   rst;
    mvm_pkg::mat_word_t     mat_in;
    logic                   mat_valid;
    logic                   mat_ready;
    mvm_pkg::vec_word_t     vec_in;
    logic                   vec_valid;
    logic                   vec_ready;
    logic                   start_valid;
    logic                   start_ready;
    logic                   res_valid;
    logic                   res_ready;
    logic [31:0]            res_data;

    logic [31:0] model_mat [0:7][0:127];  // Row by column, as the cores should hold it.
    logic [31:0] model_vec [0:127];

    mvm_pkg::mat_word_t mat_items[$];
    mvm_pkg::vec_word_t vec_items[$];

    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          cycle_cnt;

    mvm_top UUT (
        .clk         (clk),
        .rst         (rst),
        .mat_in      (mat_in),
        .mat_valid   (mat_valid),
        .mat_ready   (mat_ready),
        .vec_in      (vec_in),
        .vec_valid   (vec_valid),
        .vec_ready   (vec_ready),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res_data    (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog over the whole run.
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: no result after %0d clock cycles, the run is stuck", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] row_dot(input int r);
        logic [31:0] sum;
        int          c;
        sum = 32'd0;
        for (c = 0; c < 128; c++) begin
            sum = sum + model_mat[r][c] * model_vec[c];  // Products and sums wrap.
        end
        return sum;
    endfunction

    // Builds the load queues; a full load covers every entry once, in shuffled order.
    task automatic build_loads(input int n_mat, input int n_vec, input bit full,
                               input bit all_ones);
        int                 order[$];
        int                 i;
        int                 j;
        int                 tmp;
        logic [31:0]        r;
        mvm_pkg::mat_word_t w;
        mvm_pkg::vec_word_t v;
        mat_items.delete();
        vec_items.delete();
        for (i = 0; i < n_mat; i++) begin
            order.push_back(i);
        end
        for (i = n_mat - 1; i > 0; i--) begin
            j = int'(next_rand() % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < n_mat; i++) begin
            r = next_rand();
            w.row  = full ? 3'(order[i] / 64) : r[2:0];
            w.pair = full ? 6'(order[i] % 64) : r[8:3];
            w.data = all_ones ? {64{1'b1}} : {next_rand(), next_rand()};
            mat_items.push_back(w);
        end
        order.delete();
        for (i = 0; i < n_vec; i++) begin
            order.push_back(i);
        end
        for (i = n_vec - 1; i > 0; i--) begin
            j = int'(next_rand() % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < n_vec; i++) begin
            r = next_rand();
            v.addr = full ? 7'(order[i]) : r[6:0];
            v.data = all_ones ? 32'hffff_ffff : next_rand();
            vec_items.push_back(v);
        end
    endtask

    // Streams both queues at once with random gaps in valid.
    task automatic stream_loads();
        int          mi;
        int          vi;
        logic [31:0] r;
        mi = 0;
        vi = 0;
        while (mi < mat_items.size() || vi < vec_items.size()) begin
            @(negedge clk);
            r = next_rand();
            mat_valid = 1'b0;
            vec_valid = 1'b0;
            if (mi < mat_items.size() && r[2:0] != 3'd0) begin
                mat_valid = 1'b1;
                mat_in    = mat_items[mi];
                if (mat_ready) begin  // Accepted on the coming edge.
                    model_mat[mat_items[mi].row][{mat_items[mi].pair, 1'b0}] =
                        mat_items[mi].data[31:0];
                    model_mat[mat_items[mi].row][{mat_items[mi].pair, 1'b1}] =
                        mat_items[mi].data[63:32];
                    mi++;
                end
            end
            if (vi < vec_items.size() && r[5:3] != 3'd0) begin
                vec_valid = 1'b1;
                vec_in    = vec_items[vi];
                if (vec_ready) begin
                    model_vec[vec_items[vi].addr] = vec_items[vi].data;
                    vi++;
                end
            end
        end
        @(negedge clk);
        mat_valid = 1'b0;
        vec_valid = 1'b0;
    endtask

    // ------------------------------
    // One run and its results
    // ------------------------------

    task automatic run_and_check(input bit stall, input string tag);
        logic [31:0] expected [0:7];
        logic [31:0] r;
        int          k;
        int          latency;
        int          beats;
        for (k = 0; k < 8; k++) begin
            expected[k] = row_dot(k);
        end
        @(negedge clk);
        check_value(32'(start_ready), 32'd1, {tag, " start_ready before start"});
        start_valid = 1'b1;
        latency = 0;
        do begin
            @(negedge clk);
            start_valid = 1'b0;
            latency++;
            r = next_rand();
            mat_valid = r[0];  // Loads offered during the run must be ignored.
            mat_in    = {r[8:0], next_rand(), next_rand()};
            vec_valid = r[1];
            vec_in    = {r[15:9], next_rand()};
            check_value(32'(mat_ready), 32'd0, {tag, " mat_ready during run"});
            check_value(32'(vec_ready), 32'd0, {tag, " vec_ready during run"});
            check_value(32'(start_ready), 32'd0, {tag, " start_ready during run"});
        end while (!res_valid && latency < run_cycles);
        mat_valid = 1'b0;
        vec_valid = 1'b0;
        check_value(32'(latency), 32'd133, {tag, " start to first result"});

        beats = 0;
        while (beats < 8) begin
            if (stall) begin
                r = next_rand();
                res_ready = (r[1:0] != 2'b00);
            end else begin
                res_ready = 1'b1;
            end
            check_value(32'(res_valid), 32'd1, $sformatf("%s res_valid at beat %0d", tag, beats));
            if (!res_valid) begin
                break;
            end
            if (res_ready) begin
                check_value(res_data, expected[beats], $sformatf("%s row %0d", tag, beats));
                beats++;
            end
            @(negedge clk);
        end
        res_ready = 1'b0;
        check_value(32'(start_ready), 32'd1, {tag, " start_ready after last beat"});
        check_value(32'(mat_ready), 32'd1, {tag, " mat_ready after last beat"});
        repeat (4) begin
            check_value(32'(res_valid), 32'd0, {tag, " extra result beat"});
            @(negedge clk);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        lcg_state   = 32'hb68aa267;
        errors      = 0;
        checks      = 0;
        rst         = 1'b1;
        mat_in      = '0;
        mat_valid   = 1'b0;
        vec_in      = '0;
        vec_valid   = 1'b0;
        start_valid = 1'b0;
        res_ready   = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        check_value(32'(res_valid), 32'd0, "res_valid after reset");
        check_value(32'(start_ready), 32'd1, "start_ready after reset");
        check_value(32'(mat_ready), 32'd1, "mat_ready after reset");
        check_value(32'(vec_ready), 32'd1, "vec_ready after reset");

        build_loads(512, 128, 1'b1, 1'b0);
        stream_loads();
        run_and_check(1'b0, "run 1");

        build_loads(40, 20, 1'b0, 1'b0);   // Partial rewrite on top of run 1.
        stream_loads();
        run_and_check(1'b1, "run 2");

        build_loads(512, 128, 1'b1, 1'b1);
        stream_loads();
        run_and_check(1'b0, "run 3");

        build_loads(60, 30, 1'b0, 1'b0);
        stream_loads();
        run_and_check(1'b1, "run 4");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mvm_top.f ====
mvm_pkg.sv
mvm_core.sv
mvm_operand_store.sv
mvm_sequencer.sv
mvm_top.sv
tb_mvm_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mvm_top -f mvm_top.f

out=$(./obj_dir/Vtb_mvm_top)
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
